//--- build.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
test/tb_uart.sv

//--- Makefile
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= build.f
PASS_MSG  ?= STATUS: PASS

SRCS := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_uart.sv
// Self-checking testbench for uart_top with prescale 1, which gives 16 clocks per bit
// The bit-banged RX frames assume that same rate
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart;
    import uart_pkg::*;

    localparam int NROWS    = 10;
    localparam int BIT_CLKS = 16;

    typedef struct packed {
        frame_cfg_t cfg;
        uart_data_t word;
    } row_t;

    logic         clk;
    logic         resetn;
    uart_ctrl_t   ctrl;
    prescale_t    prescale;
    frame_cfg_t   cfg;
    fifo_level_t  tx_threshold;
    fifo_level_t  rx_threshold;
    logic         wr;
    uart_data_t   wdata;
    logic         rd;
    rx_entry_t    rdata;
    fifo_status_t tx_status;
    fifo_status_t rx_status;
    logic         tx_level_below;
    logic         rx_level_above;
    logic         rx;
    logic         tx;

    row_t       rows [NROWS];            // Loopback stimulus table
    uart_data_t sent [16];
    int         seed;
    int         pass_count;
    int         fail_count;

    uart_top DUT (
        .clk            (clk),
        .resetn         (resetn),
        .ctrl           (ctrl),
        .prescale       (prescale),
        .cfg            (cfg),
        .tx_threshold   (tx_threshold),
        .rx_threshold   (rx_threshold),
        .wr             (wr),
        .wdata          (wdata),
        .rd             (rd),
        .rdata          (rdata),
        .tx_status      (tx_status),
        .rx_status      (rx_status),
        .tx_level_below (tx_level_below),
        .rx_level_above (rx_level_above),
        .rx             (rx),
        .tx             (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;          // 40 ns period
    end

    function automatic frame_cfg_t make_cfg(logic [3:0] size, parity_t par, logic two);
        frame_cfg_t f;
        f.data_size = size;
        f.parity    = par;
        f.two_stop  = two;
        return f;
    endfunction

    function automatic rx_entry_t make_entry(logic pe, logic fe, uart_data_t d);
        rx_entry_t e;
        e.parity_error = pe;
        e.frame_error  = fe;
        e.data         = d;
        return e;
    endfunction

    function automatic fifo_status_t make_status(logic e, logic f, fifo_level_t lvl);
        fifo_status_t s;
        s.empty = e;
        s.full  = f;
        s.level = lvl;
        return s;
    endfunction

    function automatic uart_data_t mask_word(uart_data_t w, logic [3:0] size);
        return w & uart_data_t'((1 << size) - 1);   // Keep data_size low bits
    endfunction

    // Parity bit as it appears on the line
    function automatic logic parity_of(uart_data_t d, parity_t code);
        logic ones;
        ones = ^d;
        case (code)
            `UART_PAR_ODD:     return !ones;
            `UART_PAR_EVEN:    return ones;
            `UART_PAR_STICKY1: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    task automatic check_entry(input string test, input rx_entry_t got, input rx_entry_t exp);
        if (got === exp) begin
            pass_count++;
            $display("ok  %s rdata %h", test, got);
        end else begin
            fail_count++;
            $display("ERR %s rdata got %h expected %h", test, got, exp);
        end
    endtask

    task automatic check_status(input string test, input string sig,
                                input fifo_status_t got, input fifo_status_t exp);
        if (got === exp) begin
            pass_count++;
            $display("ok  %s %s %h", test, sig, got);
        end else begin
            fail_count++;
            $display("ERR %s %s got %h expected %h", test, sig, got, exp);
        end
    endtask

    task automatic check_bit(input string test, input string sig,
                             input logic got, input logic exp);
        if (got === exp) begin
            pass_count++;
            $display("ok  %s %s %h", test, sig, got);
        end else begin
            fail_count++;
            $display("ERR %s %s got %h expected %h", test, sig, got, exp);
        end
    endtask

    task automatic wait_rx_ready(input string test, input int limit);
        int n;
        n = 0;
        while (rx_status.empty && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rx_status.empty) begin
            fail_count++;
            $display("%s: no word reached the RX FIFO within %0d cycles", test, limit);
        end
    endtask

    task automatic wait_tx_drained(input string test, input int limit);
        int n;
        n = 0;
        while (!tx_status.empty && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!tx_status.empty) begin
            fail_count++;
            $display("%s: the TX FIFO did not drain within %0d cycles", test, limit);
        end
    endtask

    task automatic wait_rx_level(input string test, input fifo_level_t target, input int limit);
        int n;
        n = 0;
        while (rx_status.level < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rx_status.level < target) begin
            fail_count++;
            $display("%s: the RX FIFO never held %0d words in %0d cycles", test, target, limit);
        end
    endtask

    task automatic write_word(input uart_data_t w);
        @(negedge clk);
        wr    = 1'b1;
        wdata = w;
        @(negedge clk);                  // Level has moved by now
        wr    = 1'b0;
    endtask

    task automatic read_word();
        @(negedge clk);
        rd = 1'b1;
        @(negedge clk);
        rd = 1'b0;
    endtask

    // Drives one frame on rx, optionally with a wrong parity bit or a low first stop bit
    task automatic send_frame(input uart_data_t d, input frame_cfg_t f,
                              input logic flip_par, input logic low_stop);
        logic bits [$];
        int   k;
        bits.push_back(1'b0);            // Start bit
        for (k = 0; k < int'(f.data_size); k++) begin
            bits.push_back(d[k]);
        end
        if (f.parity != `UART_PAR_NONE) begin
            bits.push_back(parity_of(d, f.parity) ^ flip_par);
        end
        bits.push_back(!low_stop);
        if (f.two_stop) begin
            bits.push_back(1'b1);
        end
        @(negedge clk);
        foreach (bits[k]) begin
            rx = bits[k];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = 1'b1;
    endtask

    task automatic build_table();
        int i;
        rows[0].cfg = make_cfg(4'd5, `UART_PAR_NONE, 1'b0);
        rows[1].cfg = make_cfg(4'd6, `UART_PAR_ODD, 1'b0);
        rows[2].cfg = make_cfg(4'd7, `UART_PAR_EVEN, 1'b1);
        rows[3].cfg = make_cfg(4'd8, `UART_PAR_STICKY0, 1'b0);
        rows[4].cfg = make_cfg(4'd9, `UART_PAR_STICKY1, 1'b1);
        rows[5].cfg = make_cfg(4'd9, `UART_PAR_ODD, 1'b1);
        rows[6].cfg = make_cfg(4'd8, `UART_PAR_EVEN, 1'b0);
        rows[7].cfg = make_cfg(4'd5, `UART_PAR_STICKY1, 1'b0);
        rows[8].cfg = make_cfg(4'd7, `UART_PAR_NONE, 1'b1);
        rows[9].cfg = make_cfg(4'd6, `UART_PAR_STICKY0, 1'b1);
        for (i = 0; i < NROWS; i++) begin
            rows[i].word = mask_word(uart_data_t'($random(seed)), rows[i].cfg.data_size);
        end
    endtask

    task automatic run_loopback_table();
        string label;
        int    i;
        @(negedge clk);
        ctrl = '{en: 1'b1, tx_en: 1'b1, rx_en: 1'b1, loopback_en: 1'b1};
        for (i = 0; i < NROWS; i++) begin
            cfg   = rows[i].cfg;         // TX is idle between rows
            label = $sformatf("loopback row %0d", i);
            write_word(rows[i].word);
            wait_rx_ready(label, 4000);
            check_entry(label, rdata, make_entry(1'b0, 1'b0, rows[i].word));
            read_word();
            wait_tx_drained(label, 4000);
        end
    endtask

    task automatic run_error_frames();
        uart_data_t d;
        @(negedge clk);
        ctrl = '{en: 1'b1, tx_en: 1'b1, rx_en: 1'b1, loopback_en: 1'b0};
        cfg  = make_cfg(4'd8, `UART_PAR_EVEN, 1'b0);
        d    = mask_word(uart_data_t'($random(seed)), 4'd8);
        send_frame(d, cfg, 1'b1, 1'b0);
        wait_rx_ready("parity error", 400);
        check_entry("parity error", rdata, make_entry(1'b1, 1'b0, d));
        read_word();
        cfg = make_cfg(4'd7, `UART_PAR_ODD, 1'b1);   // Second stop bit brings the line back high
        d   = mask_word(uart_data_t'($random(seed)), 4'd7);
        send_frame(d, cfg, 1'b0, 1'b1);
        wait_rx_ready("framing error", 400);
        check_entry("framing error", rdata, make_entry(1'b0, 1'b1, d));
        read_word();
    endtask

    task automatic run_fifo_levels();
        string label;
        int    i;
        @(negedge clk);
        ctrl = '{en: 1'b1, tx_en: 1'b0, rx_en: 1'b1, loopback_en: 1'b0};
        cfg  = make_cfg(4'd8, `UART_PAR_NONE, 1'b0);
        for (i = 0; i < 17; i++) begin
            label = $sformatf("fill write %0d", i + 1);
            if (i < 16) begin
                sent[i] = mask_word(uart_data_t'($random(seed)), 4'd8);
                write_word(sent[i]);
            end else begin
                write_word(9'h0a5);      // Dropped by the full FIFO
            end
            check_status(label, "tx_status", tx_status,
                         make_status(1'b0, i >= 15, fifo_level_t'(i >= 15 ? 16 : i + 1)));
            check_bit(label, "tx_level_below", tx_level_below,
                      (i >= 15 ? 16 : i + 1) < int'(tx_threshold));
        end
        @(negedge clk);
        ctrl = '{en: 1'b1, tx_en: 1'b1, rx_en: 1'b1, loopback_en: 1'b1};
        wait_rx_level("rx threshold", rx_threshold + 1'b1, 2000);
        check_bit("rx threshold", "rx_level_above", rx_level_above, 1'b1);
        wait_rx_level("rx fill", 5'd16, 4000);
        wait_tx_drained("rx fill", 400);
        check_status("rx fill", "rx_status", rx_status, make_status(1'b0, 1'b1, 5'd16));
        for (i = 0; i < 16; i++) begin
            label = $sformatf("drain read %0d", i);
            check_bit(label, "rx_level_above", rx_level_above, (16 - i) > int'(rx_threshold));
            check_entry(label, rdata, make_entry(1'b0, 1'b0, sent[i]));
            read_word();
        end
        check_status("drained", "rx_status", rx_status, make_status(1'b1, 1'b0, '0));
    endtask

    initial begin
        seed         = 32'hab7d;
        pass_count   = 0;
        fail_count   = 0;
        resetn       = 1'b0;
        ctrl         = '0;
        prescale     = 16'd1;            // Tick every 2 clocks
        cfg          = make_cfg(4'd8, `UART_PAR_NONE, 1'b0);
        tx_threshold = 5'd8;
        rx_threshold = 5'd4;
        wr           = 1'b0;
        wdata        = '0;
        rd           = 1'b0;
        rx           = 1'b1;
        build_table();
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_bit("reset", "tx", tx, 1'b1);
        check_status("reset", "tx_status", tx_status, make_status(1'b1, 1'b0, '0));
        check_status("reset", "rx_status", rx_status, make_status(1'b1, 1'b0, '0));
        check_bit("reset", "rx_level_above", rx_level_above, 1'b0);
        check_bit("reset", "tx_level_below", tx_level_below, 1'b1);
        run_loopback_table();
        run_error_frames();
        run_fifo_levels();
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/uart_top.sv
// Host side uses one-cycle wr and rd strobes with no stall
// prescale and cfg should change only while both directions are idle
`timescale 1ns/1ps

module uart_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  uart_pkg::uart_ctrl_t   ctrl,
    input  uart_pkg::prescale_t    prescale,
    input  uart_pkg::frame_cfg_t   cfg,
    input  uart_pkg::fifo_level_t  tx_threshold,
    input  uart_pkg::fifo_level_t  rx_threshold,
    input  logic                   wr,
    input  uart_pkg::uart_data_t   wdata,
    input  logic                   rd,
    output uart_pkg::rx_entry_t    rdata,
    output uart_pkg::fifo_status_t tx_status,
    output uart_pkg::fifo_status_t rx_status,
    output logic                   tx_level_below,
    output logic                   rx_level_above,
    input  logic                   rx,
    output logic                   tx
);
    import uart_pkg::*;

    logic       tick;
    logic       tx_tick;
    logic       rx_tick;
    uart_data_t tx_head;               // TX FIFO head under transmission
    logic       tx_done;
    logic       rx_done;
    rx_entry_t  rx_word;
    logic       rx_line;

    assign tx_tick = tick && ctrl.tx_en;
    assign rx_tick = tick && ctrl.rx_en;
    assign rx_line = ctrl.loopback_en ? tx : rx;   // Loopback through the RX synchronizer

    uart_baud_gen u_baud_gen (
        .clk      (clk),
        .resetn   (resetn),
        .en       (ctrl.en),
        .prescale (prescale),
        .tick     (tick)
    );

    uart_fifo #(.WIDTH($bits(uart_data_t))) u_tx_fifo (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .wdata  (wdata),
        .rd     (tx_done),
        .rdata  (tx_head),
        .status (tx_status)
    );

    uart_tx u_tx (
        .clk    (clk),
        .resetn (resetn),
        .tick   (tx_tick),
        .cfg    (cfg),
        .start  (!tx_status.empty),
        .din    (tx_head),
        .done   (tx_done),
        .tx     (tx)
    );

    uart_rx u_rx (
        .clk    (clk),
        .resetn (resetn),
        .tick   (rx_tick),
        .cfg    (cfg),
        .line   (rx_line),
        .done   (rx_done),
        .entry  (rx_word)
    );

    uart_fifo #(.WIDTH($bits(rx_entry_t))) u_rx_fifo (
        .clk    (clk),
        .resetn (resetn),
        .wr     (rx_done),                  // Lost if the FIFO is full
        .wdata  (rx_word),
        .rd     (rd),
        .rdata  (rdata),
        .status (rx_status)
    );

    assign tx_level_below = (tx_status.level < tx_threshold);
    assign rx_level_above = (rx_status.level > rx_threshold);

endmodule

//--- rtl/uart_rx.sv
// Each bit is sampled at its middle and the errors travel with the word
// A start bit that reads high at its middle is dropped as noise
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 tick,
    input  uart_pkg::frame_cfg_t cfg,
    input  logic                 line,
    output logic                 done,
    output uart_pkg::rx_entry_t  entry
);
    import uart_pkg::*;

    localparam int TW = $clog2(`UART_SAMPLES);

    logic [1:0]    sync;                // Two-flop synchronizer
    logic          line_s;
    uart_state_e   state;
    logic [TW-1:0] tick_cnt;
    logic [3:0]    bit_cnt;
    uart_data_t    shreg;               // Fills from the top, LSB first on the line
    uart_data_t    aligned;
    logic          exp_par;
    logic          perr;
    logic          ferr;
    logic          bit_end;
    logic          mid_start;
    logic          last_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], line};
        end
    end

    assign line_s    = sync[1];
    assign bit_end   = tick && (tick_cnt == TW'(`UART_SAMPLES - 1));
    assign mid_start = tick && (tick_cnt == TW'(`UART_SAMPLES / 2 - 1));
    assign last_data = (bit_cnt == cfg.data_size - 4'd1);
    assign aligned   = shreg >> (`UART_MAX_DW - cfg.data_size);   // Right-align to data_size

    always_comb begin
        case (cfg.parity)
            `UART_PAR_ODD:     exp_par = ~^aligned;
            `UART_PAR_EVEN:    exp_par = ^aligned;
            `UART_PAR_STICKY1: exp_par = 1'b1;
            default:           exp_par = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            perr     <= 1'b0;
            ferr     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state != st_idle && tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (tick && !line_s) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                        perr     <= 1'b0;   // Held until here so done can read them
                        ferr     <= 1'b0;
                    end
                end
                st_start: begin
                    if (mid_start) begin
                        tick_cnt <= '0;     // Later samples land mid-bit
                        bit_cnt  <= '0;
                        state    <= line_s ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        shreg <= {line_s, shreg[`UART_MAX_DW-1:1]};
                        if (!last_data) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (cfg.parity == `UART_PAR_NONE) begin
                            state <= st_stop0;
                        end else begin
                            state <= st_parity;
                        end
                    end
                end
                st_parity: begin
                    if (bit_end) begin
                        perr  <= (line_s != exp_par);
                        state <= st_stop0;
                    end
                end
                st_stop0: begin
                    if (bit_end) begin
                        ferr <= !line_s;
                        if (cfg.two_stop) begin
                            state <= st_stop1;
                        end else begin
                            state <= st_idle;
                            done  <= 1'b1;
                        end
                    end
                end
                st_stop1: begin
                    if (bit_end) begin
                        ferr  <= ferr || !line_s;   // Either stop bit low
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign entry = '{parity_error: perr, frame_error: ferr, data: aligned};

endmodule

//--- rtl/uart_tx.sv
// cfg must stay fixed while a frame is on the line
// din is read as the frame goes out and must hold until done
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 tick,
    input  uart_pkg::frame_cfg_t cfg,
    input  logic                 start,
    input  uart_pkg::uart_data_t din,
    output logic                 done,
    output logic                 tx
);
    import uart_pkg::*;

    localparam int TW = $clog2(`UART_SAMPLES);

    uart_state_e   state;
    logic [TW-1:0] tick_cnt;            // Ticks into the current bit
    logic [3:0]    bit_cnt;             // Data bits already sent
    uart_data_t    shreg;               // Remaining data, LSB goes next
    logic          par_bit;
    logic          bit_end;
    logic          last_data;

    assign bit_end   = tick && (tick_cnt == TW'(`UART_SAMPLES - 1));
    assign last_data = (bit_cnt == cfg.data_size - 4'd1);

    // Upper bits of din are zero, so the reduction covers only the data field
    always_comb begin
        case (cfg.parity)
            `UART_PAR_ODD:     par_bit = ~^din;
            `UART_PAR_EVEN:    par_bit = ^din;
            `UART_PAR_STICKY1: par_bit = 1'b1;
            default:           par_bit = 1'b0;   // Sticky 0
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            done     <= 1'b0;
            tx       <= 1'b1;             // Line idles high
        end else begin
            done <= 1'b0;
            if (state != st_idle && tick) begin
                tick_cnt <= tick_cnt + 1'b1;   // Wraps after the last tick of a bit
            end
            case (state)
                st_idle: begin
                    // While done is high the FIFO has not popped the old head yet
                    if (start && !done) begin
                        state    <= st_start;
                        shreg    <= din;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state   <= st_data;
                        bit_cnt <= '0;
                        tx      <= shreg[0];
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        shreg <= shreg >> 1;
                        if (!last_data) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shreg[1];
                        end else if (cfg.parity == `UART_PAR_NONE) begin
                            state <= st_stop0;
                            tx    <= 1'b1;
                        end else begin
                            state <= st_parity;
                            tx    <= par_bit;
                        end
                    end
                end
                st_parity: begin
                    if (bit_end) begin
                        state <= st_stop0;
                        tx    <= 1'b1;
                    end
                end
                st_stop0: begin
                    if (bit_end) begin
                        if (cfg.two_stop) begin
                            state <= st_stop1;
                        end else begin
                            state <= st_idle;
                            done  <= 1'b1;   // Pops the TX FIFO
                        end
                    end
                end
                st_stop1: begin
                    if (bit_end) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/uart_baud_gen.sv
// Tick period is prescale + 1 enabled cycles
// Lowering prescale below the running count lets it run once around 16 bits
`timescale 1ns/1ps

module uart_baud_gen (
    input  logic                clk,
    input  logic                resetn,
    input  logic                en,
    input  uart_pkg::prescale_t prescale,
    output logic                tick
);
    import uart_pkg::*;

    prescale_t count;
    logic      wrap;

    assign wrap = (count == prescale);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (en) begin
            count <= wrap ? '0 : count + 1'b1;   // Holds while disabled
        end
    end

    assign tick = en && wrap;

endmodule

//--- rtl/uart_fifo.sv
// First-word-fall-through FIFO, rdata shows the head whenever not empty
// Writes while full and reads while empty are dropped
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_fifo #(
    parameter int WIDTH = 9
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   wr,
    input  logic [WIDTH-1:0]       wdata,
    input  logic                   rd,
    output logic [WIDTH-1:0]       rdata,
    output uart_pkg::fifo_status_t status
);
    import uart_pkg::*;

    localparam int AW    = `UART_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    head;            // Read pointer
    logic [AW-1:0]    tail;            // Write pointer
    fifo_level_t      count;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    assign empty = (count == '0);
    assign full  = (count == fifo_level_t'(DEPTH));
    assign push  = wr && !full;
    assign pop   = rd && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rdata  = mem[head];         // Head falls through
    assign status = '{empty: empty, full: full, level: count};

endmodule

//--- rtl/uart_pkg.sv
// Types shared by the UART blocks
// Data words are right-aligned with the bits above data_size held at zero
`include "uart_config.svh"

package uart_pkg;

    typedef logic [`UART_MAX_DW-1:0]     uart_data_t;
    typedef logic [`UART_PRESCALE_W-1:0] prescale_t;
    typedef logic [`UART_FIFO_AW:0]      fifo_level_t;   // One extra bit to read a full FIFO
    typedef logic [2:0]                  parity_t;

    typedef struct packed {
        logic [3:0] data_size;   // 5 to 9
        parity_t    parity;
        logic       two_stop;
    } frame_cfg_t;

    typedef struct packed {
        logic en;            // Baud generator enable
        logic tx_en;
        logic rx_en;
        logic loopback_en;   // TX line feeds the receiver
    } uart_ctrl_t;

    typedef struct packed {
        logic       parity_error;
        logic       frame_error;
        uart_data_t data;
    } rx_entry_t;

    typedef struct packed {
        logic        empty;
        logic        full;
        fifo_level_t level;
    } fifo_status_t;

    typedef enum logic [2:0] {
        st_idle, st_start, st_data, st_parity, st_stop0, st_stop1
    } uart_state_e;

endpackage

//--- rtl/uart_config.svh
// Sizing and parity codes shared by the UART RTL
// UART_SAMPLES must be a power of two so the tick counters wrap on their own
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Oversampling ticks per bit
`define UART_SAMPLES 8

// Widest data field in bits
`define UART_MAX_DW 9

// FIFO depth is 2**UART_FIFO_AW
`define UART_FIFO_AW 4

`define UART_PRESCALE_W 16

// Parity field encodings
`define UART_PAR_NONE    3'd0
`define UART_PAR_ODD     3'd1
`define UART_PAR_EVEN    3'd2
`define UART_PAR_STICKY0 3'd4
`define UART_PAR_STICKY1 3'd5

`endif
